/* common/snake_settings.svh */
// ====================
// Grid, start values and fruit border of the snake core
// Coordinates must fit SNAKE_COORD_BITS, FRUIT_SEED must be nonzero
// ====================
`ifndef SNAKE_SETTINGS_SVH
`define SNAKE_SETTINGS_SVH

`define SNAKE_H_CELLS     124   // Columns
`define SNAKE_V_CELLS     81    // Rows
`define SNAKE_COORD_BITS  7
`define SNAKE_LEN_BITS    4
`define SNAKE_BODY_SLOTS  15
`define SNAKE_START_X     8
`define SNAKE_START_Y     40
`define SNAKE_START_LEN   6     // Head plus five segments
`define FRUIT_START_X     9
`define FRUIT_START_Y     40
`define FRUIT_MARGIN      2     // Lowest legal fruit coordinate per axis
`define SCORE_MAX         99
`define EMPTY_COORD       127   // Off-grid marker for unused slots
`define FRUIT_SEED        14'h2B5D

`endif

/* common/snake_pkg.sv */
// ====================
// Shared types of the snake core, sized by snake_settings.svh
// ====================
`default_nettype none

`include "snake_settings.svh"

package snake_pkg;

    typedef struct packed {
        logic [`SNAKE_COORD_BITS-1:0] x;
        logic [`SNAKE_COORD_BITS-1:0] y;
    } cell_t;

    // One-hot heading, y grows downward
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } heading_t;

    typedef cell_t [`SNAKE_BODY_SLOTS-1:0] body_t;

    typedef enum logic [2:0] {
        IDLE         = 3'b000,
        WAIT         = 3'b001,
        COLLISION    = 3'b010,
        MOVING       = 3'b011,
        MOVE_DONE    = 3'b100,
        EATEN_FRUIT  = 3'b101,
        FRUIT_UPDATE = 3'b110,
        RESET_IDLE   = 3'b111
    } game_state_t;

    typedef struct packed {
        logic sync_reset;      // Reload start values
        logic send;            // Idle phase
        logic en_move;
        logic en_fruit;        // Fruit was eaten
        logic generate_fruit;  // Fruit search
    } game_ctrl_t;

    typedef struct packed {
        logic cw;
        logic ccw;
    } turn_t;

endpackage

`default_nettype wire

/* hdl/turn_input.sv */
// ====================
// Buttons must already be synchronous to clock_25 and debounced
// ====================
`timescale 1ns/1ps
`default_nettype none

module turn_input
    import snake_pkg::*;
(
    input  logic       clock_25,
    input  logic       reset,
    input  logic       left_p,
    input  logic       right_p,
    input  game_ctrl_t ctrl,
    output logic       start_press,
    output turn_t      turn
);

    logic [1:0] left_shift;
    logic [1:0] right_shift;
    logic       left_edge;
    logic       right_edge;

    // Rising edge found one cycle after it reaches the shifter
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            left_shift  <= 2'b00;
            right_shift <= 2'b00;
            left_edge   <= 1'b0;
            right_edge  <= 1'b0;
        end else begin
            left_shift  <= {left_shift[0], left_p};
            right_shift <= {right_shift[0], right_p};
            left_edge   <= left_shift[0] & ~left_shift[1];
            right_edge  <= right_shift[0] & ~right_shift[1];
        end
    end

    assign start_press = left_edge | right_edge;

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            turn <= '0;
        end else if (ctrl.sync_reset) begin
            turn <= '0;
        end else if (!ctrl.send && start_press) begin
            turn.cw  <= right_edge & ~left_edge;  // Both at once cancel out
            turn.ccw <= left_edge & ~right_edge;
        end else if (ctrl.en_move) begin
            turn <= '0;                           // Used up by this move
        end
    end

endmodule

`default_nettype wire

/* game_fsm/game_fsm.sv */
// ====================
// Moore FSM, game_tik pulses need at least 200 cycles between them
// ====================
`timescale 1ns/1ps
`default_nettype none

module game_fsm
    import snake_pkg::*;
(
    input  logic       clock_25,
    input  logic       reset,
    input  logic       game_tik,
    input  logic       start_press,
    input  logic       collision,
    input  logic       fruit_eaten,
    input  logic       fruit_bad,
    output game_ctrl_t ctrl,
    output logic       start,
    output logic       game_over
);

    game_state_t state;
    game_state_t state_next;

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            state <= RESET_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            RESET_IDLE:   state_next = IDLE;
            IDLE:         if (start_press) state_next = WAIT;
            WAIT:         if (game_tik) state_next = MOVING;  // Ticks elsewhere are dropped
            MOVING:       state_next = MOVE_DONE;
            MOVE_DONE: begin
                if (collision) begin
                    state_next = COLLISION;
                end else if (fruit_eaten) begin
                    state_next = EATEN_FRUIT;
                end else begin
                    state_next = WAIT;
                end
            end
            EATEN_FRUIT:  state_next = FRUIT_UPDATE;
            FRUIT_UPDATE: if (!fruit_bad) state_next = WAIT;  // Retry until the cell is legal
            COLLISION:    if (start_press) state_next = RESET_IDLE;
            default:      state_next = RESET_IDLE;
        endcase
    end

    // Outputs from the state alone
    always_comb begin
        ctrl      = '0;
        start     = 1'b1;
        game_over = 1'b0;
        case (state)
            RESET_IDLE: begin
                ctrl.sync_reset = 1'b1;
                start           = 1'b0;
            end
            IDLE: begin
                ctrl.send = 1'b1;
                start     = 1'b0;
            end
            MOVING:       ctrl.en_move = 1'b1;
            EATEN_FRUIT:  ctrl.en_fruit = 1'b1;
            FRUIT_UPDATE: ctrl.generate_fruit = 1'b1;
            COLLISION: begin
                start     = 1'b0;
                game_over = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* snake_body/snake_body.sv */
// ====================
// At most 14 body segments are in use, slot 14 keeps EMPTY_COORD
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "snake_settings.svh"

module snake_body
    import snake_pkg::*;
(
    input  logic                       clock_25,
    input  logic                       reset,
    input  game_ctrl_t                 ctrl,
    input  turn_t                      turn,
    output cell_t                      head,
    output heading_t                   heading,
    output body_t                      body,
    output logic [`SNAKE_LEN_BITS-1:0] length,
    output logic                       collision
);

    localparam cell_t START_HEAD = '{x: `SNAKE_COORD_BITS'(`SNAKE_START_X),
                                     y: `SNAKE_COORD_BITS'(`SNAKE_START_Y)};
    localparam heading_t START_HEADING = '{up: 1'b0, down: 1'b0, left: 1'b0, right: 1'b1};

    heading_t next_heading;
    cell_t    next_head;
    logic     hit_self;
    logic     hit_wall;

    // Straight line of segments to the left of the head
    function automatic body_t start_body();
        body_t b;
        for (int i = 0; i < `SNAKE_BODY_SLOTS; i++) begin
            if (i < `SNAKE_START_LEN - 1) begin
                b[i].x = `SNAKE_COORD_BITS'(`SNAKE_START_X - 1 - i);
                b[i].y = `SNAKE_COORD_BITS'(`SNAKE_START_Y);
            end else begin
                b[i].x = `SNAKE_COORD_BITS'(`EMPTY_COORD);
                b[i].y = `SNAKE_COORD_BITS'(`EMPTY_COORD);
            end
        end
        return b;
    endfunction

    // Clockwise goes right, down, left, up
    function automatic heading_t rotate(input heading_t h, input turn_t t);
        heading_t r;
        r = h;
        if (t.cw && !t.ccw) begin
            r = '{up: h.left, down: h.right, left: h.down, right: h.up};
        end else if (t.ccw && !t.cw) begin
            r = '{up: h.right, down: h.left, left: h.up, right: h.down};
        end
        return r;
    endfunction

    always_comb begin
        next_heading = rotate(heading, turn);
        next_head    = head;
        if (next_heading.up && head.y != 0) begin
            next_head.y = head.y - 1'b1;
        end else if (next_heading.down && head.y != `SNAKE_V_CELLS - 1) begin
            next_head.y = head.y + 1'b1;
        end else if (next_heading.left && head.x != 0) begin
            next_head.x = head.x - 1'b1;
        end else if (next_heading.right && head.x != `SNAKE_H_CELLS - 1) begin
            next_head.x = head.x + 1'b1;
        end
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            head    <= START_HEAD;
            heading <= START_HEADING;
            body    <= start_body();
            length  <= `SNAKE_LEN_BITS'(`SNAKE_START_LEN);
        end else if (ctrl.sync_reset) begin
            head    <= START_HEAD;
            heading <= START_HEADING;
            body    <= start_body();
            length  <= `SNAKE_LEN_BITS'(`SNAKE_START_LEN);
        end else if (ctrl.en_move) begin
            heading <= next_heading;
            head    <= next_head;
            body[0] <= head;                 // First segment takes the old head
            for (int i = 1; i < `SNAKE_BODY_SLOTS; i++) begin
                if (i < int'(length) - 1) begin
                    body[i] <= body[i-1];
                end
            end
        end else if (ctrl.en_fruit && length != `SNAKE_LEN_BITS'(`SNAKE_BODY_SLOTS)) begin
            length <= length + 1'b1;         // Saturates at 15
        end
    end

    always_comb begin
        hit_self = 1'b0;
        for (int i = 0; i < `SNAKE_BODY_SLOTS; i++) begin
            if (i < int'(length) - 1 && body[i] == head) begin
                hit_self = 1'b1;
            end
        end
        // Head on the edge it is facing
        hit_wall = (heading.left  && head.x == 0) ||
                   (heading.right && head.x == `SNAKE_H_CELLS - 1) ||
                   (heading.up    && head.y == 0) ||
                   (heading.down  && head.y == `SNAKE_V_CELLS - 1);
    end

    assign collision = hit_self | hit_wall;

endmodule

`default_nettype wire

/* fruit/fruit_ctrl.sv */
// ====================
// Search time is random and the FSM waits while fruit_bad is high
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "snake_settings.svh"

module fruit_ctrl
    import snake_pkg::*;
(
    input  logic       clock_25,
    input  logic       reset,
    input  game_ctrl_t ctrl,
    input  cell_t      head,
    input  body_t      body,
    output cell_t      fruit,
    output logic [6:0] score,
    output logic       fruit_eaten,
    output logic       fruit_bad
);

    localparam cell_t START_FRUIT = '{x: `SNAKE_COORD_BITS'(`FRUIT_START_X),
                                      y: `SNAKE_COORD_BITS'(`FRUIT_START_Y)};

    logic [2*`SNAKE_COORD_BITS-1:0] lfsr;
    cell_t                          candidate;
    logic                           on_body;
    logic                           out_of_area;

    // Free-running LFSR on x^14 + x^13 + x^12 + x^2 + 1
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            lfsr <= `FRUIT_SEED;
        end else begin
            lfsr <= {lfsr[12:0], lfsr[13] ^ lfsr[12] ^ lfsr[11] ^ lfsr[1]};
        end
    end

    assign candidate = cell_t'(lfsr);    // Upper half x, lower half y

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            fruit <= START_FRUIT;
            score <= 7'd0;
        end else if (ctrl.sync_reset) begin
            fruit <= START_FRUIT;
            score <= 7'd0;
        end else if (ctrl.en_fruit) begin
            fruit <= candidate;
            score <= (score == 7'(`SCORE_MAX)) ? 7'd0 : score + 1'b1;
        end else if (ctrl.generate_fruit && fruit_bad) begin
            fruit <= candidate;
        end
    end

    always_comb begin
        on_body = 1'b0;
        for (int i = 0; i < `SNAKE_BODY_SLOTS; i++) begin
            if (body[i] == fruit) begin
                on_body = 1'b1;
            end
        end
        out_of_area = fruit.x < `FRUIT_MARGIN || fruit.x > `SNAKE_H_CELLS - 2 ||
                      fruit.y < `FRUIT_MARGIN || fruit.y > `SNAKE_V_CELLS - 2;
    end

    assign fruit_eaten = (fruit == head);
    assign fruit_bad   = fruit_eaten | on_body | out_of_area;

endmodule

`default_nettype wire

/* hdl/body_scan.sv */
// ====================
// One segment per step, the count stops at the last slot
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "snake_settings.svh"

module body_scan
    import snake_pkg::*;
(
    input  logic                       clock_25,
    input  logic                       reset,
    input  game_ctrl_t                 ctrl,
    input  logic                       frame_tik,
    input  body_t                      body,
    output logic [`SNAKE_LEN_BITS-1:0] body_count,
    output cell_t                      body_seg
);

    localparam logic [`SNAKE_LEN_BITS-1:0] LAST = `SNAKE_LEN_BITS'(`SNAKE_BODY_SLOTS - 1);

    logic [`SNAKE_LEN_BITS-1:0] count_next;

    always_comb begin
        if (ctrl.sync_reset || ctrl.en_move) begin
            count_next = '0;                    // Restart after each move
        end else if ((ctrl.send || frame_tik) && body_count != LAST) begin
            count_next = body_count + 1'b1;
        end else begin
            count_next = body_count;
        end
    end

    // Segment follows the count on the same edge
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            body_count <= '0;
            body_seg   <= '{x: `SNAKE_COORD_BITS'(`SNAKE_START_X - 1),
                            y: `SNAKE_COORD_BITS'(`SNAKE_START_Y)};
        end else begin
            body_count <= count_next;
            body_seg   <= body[count_next];
        end
    end

endmodule

`default_nettype wire

/* hdl/snake_game_top.sv */
// ====================
// Inputs synchronous to clock_25, game_tik at least 200 cycles apart
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "snake_settings.svh"

module snake_game_top
    import snake_pkg::*;
(
    input  logic                       clock_25,
    input  logic                       reset,
    input  logic                       game_tik,
    input  logic                       frame_tik,
    input  logic                       left_p,
    input  logic                       right_p,
    output logic                       start,
    output logic                       game_over,
    output heading_t                   heading,
    output cell_t                      head,
    output cell_t                      fruit,
    output logic [6:0]                 score,
    output logic [`SNAKE_LEN_BITS-1:0] length,
    output logic [`SNAKE_LEN_BITS-1:0] body_count,
    output cell_t                      body_seg
);

    game_ctrl_t ctrl;
    turn_t      turn;
    body_t      body;
    logic       start_press;
    logic       collision;
    logic       fruit_eaten;
    logic       fruit_bad;

    turn_input turn_input_i (
        .clock_25(clock_25), .reset(reset), .left_p(left_p), .right_p(right_p),
        .ctrl(ctrl), .start_press(start_press), .turn(turn)
    );

    game_fsm game_fsm_i (
        .clock_25(clock_25), .reset(reset), .game_tik(game_tik),
        .start_press(start_press), .collision(collision), .fruit_eaten(fruit_eaten),
        .fruit_bad(fruit_bad), .ctrl(ctrl), .start(start), .game_over(game_over)
    );

    snake_body snake_body_i (
        .clock_25(clock_25), .reset(reset), .ctrl(ctrl), .turn(turn), .head(head),
        .heading(heading), .body(body), .length(length), .collision(collision)
    );

    fruit_ctrl fruit_ctrl_i (
        .clock_25(clock_25), .reset(reset), .ctrl(ctrl), .head(head), .body(body),
        .fruit(fruit), .score(score), .fruit_eaten(fruit_eaten), .fruit_bad(fruit_bad)
    );

    body_scan body_scan_i (
        .clock_25(clock_25), .reset(reset), .ctrl(ctrl), .frame_tik(frame_tik),
        .body(body), .body_count(body_count), .body_seg(body_seg)
    );

endmodule

`default_nettype wire

/* sim/snake_game_tb.sv */
// ====================
// Random play against a reference model, one game_tik every 300 cycles
// Turns, eats and collisions come from the seed so a run may end without a game over
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "snake_settings.svh"

module snake_game_tb
    import snake_pkg::*;
();

    localparam int CLOCK_PERIOD = 100;
    localparam int TICK_GAP     = 300;
    localparam int NUM_TICKS    = 80;
    localparam int CHECK_AT     = 150;  // Cycle after the tick where the move is settled
    localparam int PRESS_AT     = 160;
    localparam int H_LAST       = `SNAKE_H_CELLS - 1;
    localparam int V_LAST       = `SNAKE_V_CELLS - 1;

    logic                       clock_25;
    logic                       reset;
    logic                       game_tik;
    logic                       frame_tik;
    logic                       left_p;
    logic                       right_p;
    logic                       start;
    logic                       game_over;
    heading_t                   heading;
    cell_t                      head;
    cell_t                      fruit;
    logic [6:0]                 score;
    logic [`SNAKE_LEN_BITS-1:0] length;
    logic [`SNAKE_LEN_BITS-1:0] body_count;
    cell_t                      body_seg;

    integer seed = 32'h543b7966;
    int     errors;
    int     errors_before;
    int     tests_run;
    int     tests_failed;
    int     press;
    int     action;                     // 0 none, 1 start, 2 restart

    // Reference model with dir 0 right, 1 down, 2 left, 3 up
    int     m_x;
    int     m_y;
    int     m_dir;
    int     m_len;
    int     m_score;
    int     m_turn;                     // +1 clockwise, -1 counter-clockwise
    int     m_bx [`SNAKE_BODY_SLOTS];
    int     m_by [`SNAKE_BODY_SLOTS];
    int     m_count;                    // Expected scan index
    logic   count_known;
    logic   m_started;
    logic   m_over;

    snake_game_top snake_game_top_i (
        .clock_25(clock_25), .reset(reset), .game_tik(game_tik), .frame_tik(frame_tik),
        .left_p(left_p), .right_p(right_p), .start(start), .game_over(game_over),
        .heading(heading), .head(head), .fruit(fruit), .score(score), .length(length),
        .body_count(body_count), .body_seg(body_seg)
    );

    initial begin
        clock_25 = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock_25 = ~clock_25;
    end

    initial begin
        #((NUM_TICKS * TICK_GAP + 2000) * CLOCK_PERIOD);
        $display("Timeout: the run did not finish in the expected time");
        $display(">>> FAIL");
        $finish;
    end

    task automatic model_reset();
        m_x       = `SNAKE_START_X;
        m_y       = `SNAKE_START_Y;
        m_dir     = 0;
        m_len     = `SNAKE_START_LEN;
        m_score   = 0;
        m_turn    = 0;
        m_started = 1'b0;
        m_over    = 1'b0;
        for (int i = 0; i < `SNAKE_BODY_SLOTS; i++) begin
            m_bx[i] = (i < `SNAKE_START_LEN - 1) ? `SNAKE_START_X - 1 - i : `EMPTY_COORD;
            m_by[i] = (i < `SNAKE_START_LEN - 1) ? `SNAKE_START_Y : `EMPTY_COORD;
        end
    endtask

    function automatic heading_t heading_of(input int dir);
        heading_t h;
        h = '0;
        case (dir)
            0:       h.right = 1'b1;
            1:       h.down  = 1'b1;
            2:       h.left  = 1'b1;
            default: h.up    = 1'b1;
        endcase
        return h;
    endfunction

    // One game step against the fruit fx, fy seen before the move
    task automatic model_move(input int fx, input int fy);
        logic hit;
        m_dir  = (m_dir + m_turn + 4) % 4;
        m_turn = 0;
        for (int i = m_len - 2; i > 0; i--) begin
            m_bx[i] = m_bx[i-1];
            m_by[i] = m_by[i-1];
        end
        m_bx[0] = m_x;
        m_by[0] = m_y;
        case (m_dir)
            0:       if (m_x != H_LAST) m_x++;
            1:       if (m_y != V_LAST) m_y++;
            2:       if (m_x != 0) m_x--;
            default: if (m_y != 0) m_y--;
        endcase
        hit = (m_dir == 0 && m_x == H_LAST) || (m_dir == 1 && m_y == V_LAST) ||
              (m_dir == 2 && m_x == 0) || (m_dir == 3 && m_y == 0);
        for (int i = 0; i < m_len - 1; i++) begin
            if (m_bx[i] == m_x && m_by[i] == m_y) hit = 1'b1;
        end
        if (hit) begin
            m_over = 1'b1;
        end else if (m_x == fx && m_y == fy) begin
            m_score = (m_score == `SCORE_MAX) ? 0 : m_score + 1;
            if (m_len < `SNAKE_BODY_SLOTS) m_len++;
        end
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reset_values();
        check_value("start", start, 0);
        check_value("game_over", game_over, 0);
        check_value("head.x", head.x, `SNAKE_START_X);
        check_value("head.y", head.y, `SNAKE_START_Y);
        check_value("heading", int'(heading), int'(heading_of(0)));
        check_value("length", length, `SNAKE_START_LEN);
        check_value("score", score, 0);
        check_value("fruit.x", fruit.x, `FRUIT_START_X);
        check_value("fruit.y", fruit.y, `FRUIT_START_Y);
    endtask

    task automatic check_after_tick();
        logic bad;
        check_value("start", start, int'(m_started && !m_over));
        check_value("game_over", game_over, int'(m_over));
        check_value("head.x", head.x, m_x);
        check_value("head.y", head.y, m_y);
        check_value("heading", int'(heading), int'(heading_of(m_dir)));
        check_value("length", length, m_len);
        check_value("score", score, m_score);
        if (m_started && !m_over) begin
            bad = fruit.x < `FRUIT_MARGIN || fruit.x > `SNAKE_H_CELLS - 2 ||
                  fruit.y < `FRUIT_MARGIN || fruit.y > `SNAKE_V_CELLS - 2 ||
                  (fruit.x == m_x && fruit.y == m_y);
            for (int i = 0; i < `SNAKE_BODY_SLOTS; i++) begin
                if (fruit.x == m_bx[i] && fruit.y == m_by[i]) bad = 1'b1;
            end
            if (bad) begin
                $display("Fruit at %0d,%0d lies outside the border or on the snake at %0t",
                         fruit.x, fruit.y, $time);
                errors++;
            end
        end
    endtask

    task automatic check_scan();
        check_value("body_seg.x", body_seg.x, m_bx[body_count]);
        check_value("body_seg.y", body_seg.y, m_by[body_count]);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("test %s failed", name);
        end else begin
            $display("test %s ok", name);
        end
        errors_before = errors;
    endtask

    initial begin
        reset         = 1'b0;
        game_tik      = 1'b0;
        frame_tik     = 1'b0;
        left_p        = 1'b0;
        right_p       = 1'b0;
        errors        = 0;
        errors_before = 0;
        tests_run     = 0;
        tests_failed  = 0;
        m_count       = 0;
        count_known   = 1'b0;
        model_reset();
        repeat (5) @(negedge clock_25);
        reset = 1'b1;
        @(negedge clock_25);
        check_reset_values();
        report_test("reset");
        for (int t = 0; t < NUM_TICKS; t++) begin
            press  = 0;
            action = 0;
            for (int c = 0; c < TICK_GAP; c++) begin
                @(negedge clock_25);
                if (c == CHECK_AT) begin
                    check_after_tick();
                    count_known = m_started && !m_over;  // Scan restarted by this move
                    m_count     = 0;
                end
                if (c >= CHECK_AT && m_started && !m_over) check_scan();
                if (c >= CHECK_AT && count_known) begin
                    check_value("body_count", body_count, m_count);
                end
                if (c == PRESS_AT + 10 && action == 1) check_value("start", start, 1);
                if (c == PRESS_AT + 10 && action == 2) check_reset_values();
                if (c == 0 && m_started && !m_over) model_move(fruit.x, fruit.y);
                if (c == PRESS_AT) begin
                    press = $unsigned($random(seed)) % 3;   // 0 none, 1 left, 2 right
                    if (press != 0) begin
                        if (!m_started) begin
                            m_started = 1'b1;
                            action    = 1;
                        end else if (m_over) begin
                            model_reset();
                            action = 2;
                        end else begin
                            m_turn = (press == 1) ? -1 : 1;
                        end
                    end
                end
                game_tik  = (c == 0);
                frame_tik = (c >= CHECK_AT) ? $random(seed) & 1 : 1'b0;
                left_p    = press == 1 && c >= PRESS_AT && c < PRESS_AT + 4;
                right_p   = press == 2 && c >= PRESS_AT && c < PRESS_AT + 4;
                if (count_known && frame_tik && m_count < `SNAKE_BODY_SLOTS - 1) begin
                    m_count++;                      // Stops at the last slot
                end
            end
            report_test($sformatf("tick %0d", t + 1));
        end
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+common
common/snake_pkg.sv
hdl/turn_input.sv
game_fsm/game_fsm.sv
snake_body/snake_body.sv
fruit/fruit_ctrl.sv
hdl/body_scan.sv
hdl/snake_game_top.sv
sim/snake_game_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module snake_game_tb \
    -Mdir obj_dir -o snake_game_sim -f project.f || exit 1
./obj_dir/snake_game_sim | tee /dev/stderr | grep -qx '>>> PASS' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
